//--- list.f
source/l2dir_pkg.sv
source/l2dir_ctl.sv
source/l2dir_panel.sv
source/l2dir_rd_mux.sv
source/l2dir_top.sv
verif/l2dir_tb.sv

//--- Makefile
# Verilator build of the L2 directory testbench

TOP := l2dir_tb

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): list.f source/*.sv verif/*.sv
	verilator --binary --timing --assert -f list.f --top-module $(TOP) -Mdir obj_dir

run: obj_dir/V$(TOP)
	-./obj_dir/V$(TOP) > run.log 2>&1
	cat run.log
	grep -q "Result: PASSED" run.log

lint:
	verilator --lint-only -Wall --timing -f list.f --top-module $(TOP)

clean:
	rm -rf obj_dir run.log

//--- verif/l2dir_tb.sv
// L2 directory bank testbench
// Reference model, LFSR stimulus and concurrent checks on the outputs
`timescale 1ns/1ps
`default_nettype none

module l2dir_tb;

   import l2dir_pkg::*;

   localparam int TAG_W  = 30;
   localparam int WORD_W = TAG_W + 1;  // {valid, tag}

   // Run length in cycles
   localparam int RESET_CYCLES    = 3;
   localparam int DIRECTED_CYCLES = 40;   // Upper bound on the directed phases
   localparam int RANDOM_CYCLES   = 400;
   localparam int DRAIN_CYCLES    = 4;
   localparam int TIMEOUT_CYCLES  = RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES
                                    + DRAIN_CYCLES + 20;

   logic                  rclk = 1'b0;
   logic                  rst;
   logic                  rd_en, wr_en, dir_clear;
   logic [NUM_PANELS-1:0] rw_dec, lkup_en;
   logic [ENTRY_W-1:0]    rw_entry;
   logic [TAG_W-1:0]      wr_tag, lkup_tag;
   logic [NUM_GROUPS-1:0] inval_mask;
   logic [TAG_W:0]        rd_data;
   logic                  rd_valid, lkup_valid;
   logic [NUM_PANELS-1:0] lkup_hit;

   // Reference model state
   logic [TAG_W-1:0]      mdl_tag [NUM_PANELS][NUM_ENTRIES];
   logic                  mdl_vld [NUM_PANELS][NUM_ENTRIES];
   logic [TAG_W:0]        exp_rd_c5, exp_rd_c6;      // Expected read word per stage
   logic                  exp_rd_v_c5, exp_rd_v_c6;
   logic [NUM_PANELS-1:0] exp_hit;
   logic                  exp_lkv;

   logic [19:0] lfsr_state = 20'd92287;
   int          cycle_cnt  = 0;

   always #10 rclk = ~rclk;  // 20 ns period

   l2dir_top #(
      .TAG_W (TAG_W)
   ) dut0 (
      .rclk       (rclk),
      .rst        (rst),
      .rd_en      (rd_en),
      .wr_en      (wr_en),
      .rw_dec     (rw_dec),
      .rw_entry   (rw_entry),
      .wr_tag     (wr_tag),
      .lkup_en    (lkup_en),
      .lkup_tag   (lkup_tag),
      .inval_mask (inval_mask),
      .dir_clear  (dir_clear),
      .rd_data    (rd_data),
      .rd_valid   (rd_valid),
      .lkup_hit   (lkup_hit),
      .lkup_valid (lkup_valid)
   );

   // x^20 + x^17 + 1 stepped once per bit taken
   function automatic logic [31:0] draw_bits(input int n);
      logic [31:0] val;
      val = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_state = {lfsr_state[18:0], lfsr_state[19] ^ lfsr_state[16]};
         val        = {val[30:0], lfsr_state[0]};
      end
      return val;
   endfunction

   // Small tag pool so lookups find matches
   function automatic logic [TAG_W-1:0] pool_tag(input logic [1:0] idx);
      case (idx)
         2'd0:    return 30'h12345678;
         2'd1:    return 30'h0BADC0DE;
         2'd2:    return 30'h2F0F0F0F;
         default: return 30'h3C3C3C3C;
      endcase
   endfunction

   task automatic report_mismatch(input string name, input logic [TAG_W:0] exp_val,
                                  input logic [TAG_W:0] act_val);
      $display("ERR %0t: %s expected %h got %h", $time, name, exp_val, act_val);
      $display("Result: FAILED");
      $fatal(1, "output mismatch");
   endtask

   // Step to the next falling edge with all strobes idle
   task automatic tick();
      @(negedge rclk);
      rd_en      = 1'b0;
      wr_en      = 1'b0;
      dir_clear  = 1'b0;
      lkup_en    = '0;
      inval_mask = '0;
   endtask

   task automatic read_req(input int p, input int e);
      rd_en    = 1'b1;
      rw_dec   = 4'b0001 << p;
      rw_entry = ENTRY_W'(e);
   endtask

   task automatic write_req(input int p, input int e, input logic [TAG_W-1:0] tag);
      wr_en    = 1'b1;
      rw_dec   = 4'b0001 << p;
      rw_entry = ENTRY_W'(e);
      wr_tag   = tag;
   endtask

   task automatic lookup_req(input logic [NUM_PANELS-1:0] en, input logic [TAG_W-1:0] tag,
                             input logic [NUM_GROUPS-1:0] mask);
      lkup_en    = en;
      lkup_tag   = tag;
      inval_mask = mask;
   endtask

   task automatic random_cycle();
      logic [1:0] pnl;
      tick();
      pnl      = 2'(draw_bits(2));
      rw_dec   = 4'b0001 << pnl;            // Always one panel
      rw_entry = ENTRY_W'(draw_bits(ENTRY_W));
      rd_en    = 1'(draw_bits(1));
      wr_en    = 1'(draw_bits(1));
      wr_tag   = pool_tag(2'(draw_bits(2)));
      if (draw_bits(1) != 0) begin
         lkup_en    = 4'(draw_bits(4));
         lkup_tag   = pool_tag(2'(draw_bits(2)));
         inval_mask = 8'(draw_bits(8));
      end
      dir_clear = (draw_bits(6) == 0);      // Rare clear
   endtask

   // Reference model that compares against the state before the edge
   always @(posedge rclk) begin : ref_model
      logic [NUM_PANELS-1:0] hit;
      logic [TAG_W:0]        rd_word;
      logic                  rd_any;
      hit     = '0;
      rd_word = '0;
      rd_any  = 1'b0;
      if (rst) begin
         for (int p = 0; p < NUM_PANELS; p++) begin
            for (int e = 0; e < NUM_ENTRIES; e++) begin
               mdl_vld[p][e] = 1'b0;
            end
         end
         exp_rd_c5   <= '0;
         exp_rd_c6   <= '0;
         exp_rd_v_c5 <= 1'b0;
         exp_rd_v_c6 <= 1'b0;
         exp_hit     <= '0;
         exp_lkv     <= 1'b0;
      end else begin
         for (int p = 0; p < NUM_PANELS; p++) begin
            if (rd_en && rw_dec[p]) begin
               rd_word = {mdl_vld[p][rw_entry], mdl_tag[p][rw_entry]};  // Old contents
               rd_any  = 1'b1;
            end
            for (int e = 0; e < NUM_ENTRIES; e++) begin
               if (lkup_en[p] && mdl_vld[p][e] && mdl_tag[p][e] == lkup_tag) begin
                  hit[p] = 1'b1;
               end
            end
         end
         exp_rd_c5   <= rd_word;
         exp_rd_v_c5 <= rd_any;
         exp_rd_c6   <= exp_rd_c5;
         exp_rd_v_c6 <= exp_rd_v_c5;
         exp_hit     <= hit;
         exp_lkv     <= |lkup_en;
         // Clear first, then invalidate, then write
         for (int p = 0; p < NUM_PANELS; p++) begin
            for (int e = 0; e < NUM_ENTRIES; e++) begin
               if (dir_clear) begin
                  mdl_vld[p][e] = 1'b0;
               end else if (lkup_en[p] && mdl_vld[p][e] && mdl_tag[p][e] == lkup_tag
                            && inval_mask[e / 8]) begin
                  mdl_vld[p][e] = 1'b0;   // Group of 8 entries
               end
            end
            if (wr_en && rw_dec[p] && !dir_clear) begin
               mdl_tag[p][rw_entry] = wr_tag;
               mdl_vld[p][rw_entry] = 1'b1;
            end
         end
      end
   end

   a_rd_valid : assert property (@(posedge rclk) disable iff (rst)
      rd_valid == exp_rd_v_c6)
      else report_mismatch("rd_valid", WORD_W'($sampled(exp_rd_v_c6)),
                           WORD_W'($sampled(rd_valid)));

   a_rd_vbit : assert property (@(posedge rclk) disable iff (rst)
      exp_rd_v_c6 |-> rd_data[TAG_W] == exp_rd_c6[TAG_W])
      else report_mismatch("rd_data valid bit", WORD_W'($sampled(exp_rd_c6[TAG_W])),
                           WORD_W'($sampled(rd_data[TAG_W])));

   // Tag only defined once the entry is valid
   a_rd_tag : assert property (@(posedge rclk) disable iff (rst)
      (exp_rd_v_c6 && exp_rd_c6[TAG_W]) |-> rd_data[TAG_W-1:0] == exp_rd_c6[TAG_W-1:0])
      else report_mismatch("rd_data tag", $sampled(exp_rd_c6), $sampled(rd_data));

   a_lkup_valid : assert property (@(posedge rclk) disable iff (rst)
      lkup_valid == exp_lkv)
      else report_mismatch("lkup_valid", WORD_W'($sampled(exp_lkv)),
                           WORD_W'($sampled(lkup_valid)));

   a_lkup_hit : assert property (@(posedge rclk) disable iff (rst)
      lkup_hit == exp_hit)
      else report_mismatch("lkup_hit", WORD_W'($sampled(exp_hit)),
                           WORD_W'($sampled(lkup_hit)));

   // Hang guard
   always @(posedge rclk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= TIMEOUT_CYCLES) begin
         $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("Result: FAILED");
         $fatal(1, "timeout");
      end
   end

   initial begin
      rst        = 1'b1;
      rd_en      = 1'b0;
      wr_en      = 1'b0;
      dir_clear  = 1'b0;
      rw_dec     = '0;
      rw_entry   = '0;
      wr_tag     = '0;
      lkup_en    = '0;
      lkup_tag   = '0;
      inval_mask = '0;
      repeat (RESET_CYCLES) @(negedge rclk);
      rst = 1'b0;

      // Empty after reset
      tick();
      tick();
      for (int p = 0; p < NUM_PANELS; p++) begin
         tick();
         read_req(p, p * 7);
      end

      // Write then read on every panel to cover every mux path
      for (int p = 0; p < NUM_PANELS; p++) begin
         tick();
         write_req(p, 10 + p, pool_tag(2'(p)));
         tick();
         read_req(p, 10 + p);
      end

      // Same-cycle read sees the old tag
      tick();
      write_req(1, 33, pool_tag(2'd0));
      tick();
      read_req(1, 33);
      write_req(1, 33, pool_tag(2'd1));
      tick();
      read_req(1, 33);

      // Lookup with group invalidate
      tick();
      write_req(0, 3, pool_tag(2'd2));    // Group 0
      tick();
      write_req(0, 20, pool_tag(2'd2));   // Group 2 outside the mask
      tick();
      write_req(1, 9, pool_tag(2'd2));    // Group 1
      tick();
      write_req(2, 3, pool_tag(2'd3));
      tick();
      write_req(3, 7, pool_tag(2'd1));
      tick();
      lookup_req(4'b0111, pool_tag(2'd2), 8'b0000_0011);
      tick();
      read_req(0, 3);
      tick();
      read_req(0, 20);
      tick();
      read_req(1, 9);
      tick();
      read_req(2, 3);
      tick();
      lookup_req(4'b1111, pool_tag(2'd2), 8'b0000_0000);
      // Write wins over an invalidate of the same entry
      tick();
      lookup_req(4'b1000, pool_tag(2'd1), 8'hFF);
      write_req(3, 7, pool_tag(2'd1));
      tick();
      read_req(3, 7);

      // Clear also blocks the write beside it
      tick();
      write_req(2, 40, pool_tag(2'd3));
      tick();
      dir_clear = 1'b1;
      write_req(3, 41, pool_tag(2'd3));
      tick();
      read_req(2, 40);
      tick();
      read_req(3, 41);
      repeat (DRAIN_CYCLES) tick();

      repeat (RANDOM_CYCLES) random_cycle();
      repeat (DRAIN_CYCLES) tick();

      $display("Result: PASSED");
      $finish;
   end

endmodule : l2dir_tb

`default_nettype wire

//--- source/l2dir_top.sv
// L2 directory bank top
// Control, four tag panels and the read mux; lookup valid tracked here
`timescale 1ns/1ps
`default_nettype none

module l2dir_top #(
   parameter int TAG_W = 30
) (
   input  wire                              rclk,
   input  wire                              rst,
   // c4 request strobes
   input  wire                              rd_en,
   input  wire                              wr_en,
   input  wire [l2dir_pkg::NUM_PANELS-1:0]  rw_dec,
   input  wire [l2dir_pkg::ENTRY_W-1:0]     rw_entry,
   input  wire [TAG_W-1:0]                  wr_tag,
   input  wire [l2dir_pkg::NUM_PANELS-1:0]  lkup_en,
   input  wire [TAG_W-1:0]                  lkup_tag,
   input  wire [l2dir_pkg::NUM_GROUPS-1:0]  inval_mask,
   input  wire                              dir_clear,
   // Results
   output logic [TAG_W:0]                   rd_data,     // Top bit is valid
   output logic                             rd_valid,    // Two cycles after rd_en
   output logic [l2dir_pkg::NUM_PANELS-1:0] lkup_hit,
   output logic                             lkup_valid   // One cycle after lkup_en
);

   import l2dir_pkg::*;

   // Control to panels
   logic [NUM_PANELS-1:0] rd_data_en_c4;
   logic [NUM_PANELS-1:0] wr_data_en_c4;
   logic [NUM_PANELS-1:0] cam_en_c4;
   logic [ENTRY_W-1:0]    rw_entry_c4;
   logic [NUM_GROUPS-1:0] inval_mask_c4;
   logic                  warm_rst_c4;

   // Control to mux
   logic rd_data_sel0_c5, rd_data_sel1_c5;
   logic rd_data_sel_left_c6, rd_data_sel_right_c6;

   logic [TAG_W:0] rd_entry_c5 [NUM_PANELS];  // Panel read words

   l2dir_ctl u_ctl (
      .rclk                 (rclk),
      .rst                  (rst),
      .rd_en                (rd_en),
      .wr_en                (wr_en),
      .rw_dec               (rw_dec),
      .rw_entry             (rw_entry),
      .lkup_en              (lkup_en),
      .inval_mask           (inval_mask),
      .dir_clear            (dir_clear),
      .rd_data_en_c4        (rd_data_en_c4),
      .wr_data_en_c4        (wr_data_en_c4),
      .cam_en_c4            (cam_en_c4),
      .rw_entry_c4          (rw_entry_c4),
      .inval_mask_c4        (inval_mask_c4),
      .warm_rst_c4          (warm_rst_c4),
      .rd_data_sel0_c5      (rd_data_sel0_c5),
      .rd_data_sel1_c5      (rd_data_sel1_c5),
      .rd_data_sel_left_c6  (rd_data_sel_left_c6),
      .rd_data_sel_right_c6 (rd_data_sel_right_c6),
      .rd_valid_c6          (rd_valid)
   );

   // Panels 0..3 are LT, RT, LB, RB
   for (genvar p = 0; p < NUM_PANELS; p++) begin : g_panel
      l2dir_panel #(
         .TAG_W (TAG_W)
      ) u_panel (
         .rclk        (rclk),
         .rst         (rst),
         .rd_en       (rd_data_en_c4[p]),
         .wr_en       (wr_data_en_c4[p]),
         .cam_en      (cam_en_c4[p]),
         .warm_rst    (warm_rst_c4),
         .entry       (rw_entry_c4),
         .wr_tag      (wr_tag),
         .lkup_tag    (lkup_tag),
         .inval_mask  (inval_mask_c4),
         .rd_entry_c5 (rd_entry_c5[p]),
         .lkup_hit_c5 (lkup_hit[p])    // Hits are registered in the panel
      );
   end

   l2dir_rd_mux #(
      .TAG_W (TAG_W)
   ) u_rd_mux (
      .rclk           (rclk),
      .rst            (rst),
      .rd_entry_lt_c5 (rd_entry_c5[PANEL_LT]),
      .rd_entry_rt_c5 (rd_entry_c5[PANEL_RT]),
      .rd_entry_lb_c5 (rd_entry_c5[PANEL_LB]),
      .rd_entry_rb_c5 (rd_entry_c5[PANEL_RB]),
      .sel0_c5        (rd_data_sel0_c5),
      .sel1_c5        (rd_data_sel1_c5),
      .sel_left_c6    (rd_data_sel_left_c6),
      .sel_right_c6   (rd_data_sel_right_c6),
      .rd_data_c6     (rd_data)
   );

   // Lookup result is valid one cycle on
   always_ff @(posedge rclk) begin
      if (rst) begin
         lkup_valid <= 1'b0;
      end else begin
         lkup_valid <= |lkup_en;
      end
   end

endmodule : l2dir_top

`default_nettype wire

//--- source/l2dir_rd_mux.sv
// L2 directory read-data select
// Top/bottom per side at c5, then left/right at c6
`timescale 1ns/1ps
`default_nettype none

module l2dir_rd_mux #(
   parameter int TAG_W = 30
) (
   input  wire             rclk,
   input  wire             rst,
   input  wire [TAG_W:0]   rd_entry_lt_c5,
   input  wire [TAG_W:0]   rd_entry_rt_c5,
   input  wire [TAG_W:0]   rd_entry_lb_c5,
   input  wire [TAG_W:0]   rd_entry_rb_c5,
   input  wire             sel0_c5,       // Left-top when high
   input  wire             sel1_c5,       // Right-top when high
   input  wire             sel_left_c6,
   input  wire             sel_right_c6,
   output logic [TAG_W:0]  rd_data_c6     // {valid, tag}
);

   logic [TAG_W:0] left_c5, right_c5;
   logic [TAG_W:0] left_c6, right_c6;

   // Per-side top/bottom pick
   assign left_c5  = sel0_c5 ? rd_entry_lt_c5 : rd_entry_lb_c5;
   assign right_c5 = sel1_c5 ? rd_entry_rt_c5 : rd_entry_rb_c5;

   // Side words into c6
   always_ff @(posedge rclk) begin
      left_c6  <= left_c5;
      right_c6 <= right_c5;
   end

   // AND-OR select gives zero when no read lands
   assign rd_data_c6 = ({(TAG_W+1){sel_left_c6}}  & left_c6) |
                       ({(TAG_W+1){sel_right_c6}} & right_c6);

   // Holds only while the control keeps one read per cycle
   a_one_side : assert property (
      @(posedge rclk) disable iff (rst)
      !(sel_left_c6 && sel_right_c6))
      else $error("l2dir_rd_mux: left and right selected together");

endmodule : l2dir_rd_mux

`default_nettype wire

//--- source/l2dir_panel.sv
// One L2 directory panel of 64 tags with valid bits
// Registered read, write port and a CAM lookup with grouped invalidate
`timescale 1ns/1ps
`default_nettype none

module l2dir_panel #(
   parameter int TAG_W = 30
) (
   input  wire                              rclk,
   input  wire                              rst,
   input  wire                              rd_en,
   input  wire                              wr_en,
   input  wire                              cam_en,
   input  wire                              warm_rst,    // Clears every valid bit
   input  wire [l2dir_pkg::ENTRY_W-1:0]     entry,       // Read/write index
   input  wire [TAG_W-1:0]                  wr_tag,
   input  wire [TAG_W-1:0]                  lkup_tag,
   input  wire [l2dir_pkg::NUM_GROUPS-1:0]  inval_mask,  // One bit per entry group
   output logic [TAG_W:0]                   rd_entry_c5, // {valid, tag}
   output logic                             lkup_hit_c5
);

   import l2dir_pkg::*;

   // Storage
   logic [TAG_W-1:0]       tags [NUM_ENTRIES];
   logic [NUM_ENTRIES-1:0] vld;

   // CAM results
   logic [NUM_ENTRIES-1:0] match;      // Valid entries equal to lkup_tag
   logic [NUM_ENTRIES-1:0] inval_hit;  // Matches inside a masked group

   // Compare against the state held before this edge
   always_comb begin
      logic [GROUP_W-1:0] grp;
      grp = '0;
      for (int i = 0; i < NUM_ENTRIES; i++) begin
         match[i]     = cam_en & vld[i] & (tags[i] == lkup_tag);
         grp          = GROUP_W'(i >> (ENTRY_W - GROUP_W));  // Upper index bits
         inval_hit[i] = match[i] & inval_mask[grp];
      end
   end

   // Tags change only on a write
   always_ff @(posedge rclk) begin
      if (wr_en) begin
         tags[entry] <= wr_tag;
      end
   end

   // Valid bits
   // Clear beats everything and write beats invalidate
   always_ff @(posedge rclk) begin
      if (rst || warm_rst) begin
         vld <= '0;
      end else begin
         vld <= vld & ~inval_hit;
         if (wr_en) begin
            vld[entry] <= 1'b1;
         end
      end
   end

   // Read port
   // Old contents on a same-cycle write
   always_ff @(posedge rclk) begin
      if (rd_en) begin
         rd_entry_c5 <= {vld[entry], tags[entry]};
      end
   end

   // Any match in this panel
   always_ff @(posedge rclk) begin
      if (rst) begin
         lkup_hit_c5 <= 1'b0;
      end else begin
         lkup_hit_c5 <= |match;
      end
   end

   // The control blocks writes during a clear
   a_no_wr_on_clear : assert property (
      @(posedge rclk) disable iff (rst)
      !(wr_en && warm_rst))
      else $error("l2dir_panel: write and clear in the same cycle");

endmodule : l2dir_panel

`default_nettype wire

//--- source/l2dir_ctl.sv
// L2 directory control
// Turns the c4 request into panel enables and pipes read selects to c5/c6
`timescale 1ns/1ps
`default_nettype none

module l2dir_ctl (
   input  wire                              rclk,
   input  wire                              rst,
   // c4 request
   input  wire                              rd_en,
   input  wire                              wr_en,
   input  wire [l2dir_pkg::NUM_PANELS-1:0]  rw_dec,      // One-hot panel select
   input  wire [l2dir_pkg::ENTRY_W-1:0]     rw_entry,
   input  wire [l2dir_pkg::NUM_PANELS-1:0]  lkup_en,
   input  wire [l2dir_pkg::NUM_GROUPS-1:0]  inval_mask,
   input  wire                              dir_clear,
   // To the panels
   output logic [l2dir_pkg::NUM_PANELS-1:0] rd_data_en_c4,
   output logic [l2dir_pkg::NUM_PANELS-1:0] wr_data_en_c4,
   output logic [l2dir_pkg::NUM_PANELS-1:0] cam_en_c4,
   output logic [l2dir_pkg::ENTRY_W-1:0]    rw_entry_c4,
   output logic [l2dir_pkg::NUM_GROUPS-1:0] inval_mask_c4,
   output logic                             warm_rst_c4,
   // To the read mux
   output logic                             rd_data_sel0_c5,      // Left-top over left-bottom
   output logic                             rd_data_sel1_c5,      // Right-top over right-bottom
   output logic                             rd_data_sel_left_c6,
   output logic                             rd_data_sel_right_c6,
   output logic                             rd_valid_c6
);

   import l2dir_pkg::*;

   logic [NUM_PANELS-1:0] rd_data_en_c5;  // Read enables one stage on
   logic                  rd_data_sel_left_c5;
   logic                  rd_data_sel_right_c5;

   assign warm_rst_c4 = dir_clear;  // Clear drives the panel valid reset

   // Panel enables
   assign rd_data_en_c4 = {NUM_PANELS{rd_en}} & rw_dec;
   assign wr_data_en_c4 = {NUM_PANELS{wr_en & ~warm_rst_c4}} & rw_dec;  // No write over a clear
   assign cam_en_c4     = lkup_en;

   assign rw_entry_c4   = rw_entry;    // Shared entry index
   assign inval_mask_c4 = inval_mask;

   // c4 -> c5
   always_ff @(posedge rclk) begin
      if (rst) begin
         rd_data_en_c5 <= '0;
      end else begin
         rd_data_en_c5 <= rd_data_en_c4;
      end
   end

   // Top/bottom choice per side
   assign rd_data_sel0_c5 = rd_data_en_c5[PANEL_LT];
   assign rd_data_sel1_c5 = rd_data_en_c5[PANEL_RT];

   // Side that holds the read
   assign rd_data_sel_left_c5  = rd_data_en_c5[PANEL_LT] | rd_data_en_c5[PANEL_LB];
   assign rd_data_sel_right_c5 = rd_data_en_c5[PANEL_RT] | rd_data_en_c5[PANEL_RB];

   // c5 -> c6
   always_ff @(posedge rclk) begin
      if (rst) begin
         rd_data_sel_left_c6  <= 1'b0;
         rd_data_sel_right_c6 <= 1'b0;
         rd_valid_c6          <= 1'b0;
      end else begin
         rd_data_sel_left_c6  <= rd_data_sel_left_c5;
         rd_data_sel_right_c6 <= rd_data_sel_right_c5;
         rd_valid_c6          <= |rd_data_en_c5;  // Read lands at c6
      end
   end

   // A read or write names at most one panel
   a_rw_dec_onehot : assert property (
      @(posedge rclk) disable iff (rst)
      (rd_en || wr_en) |-> $onehot0(rw_dec))
      else $error("l2dir_ctl: rw_dec not one-hot on a read or write");

endmodule : l2dir_ctl

`default_nettype wire

//--- source/l2dir_pkg.sv
// L2 directory geometry shared by the control, panels and top
// Four panels of 64 tag entries, invalidated in groups of 8
`default_nettype none

package l2dir_pkg;

   // Panel order is 0 left-top, 1 right-top, 2 left-bottom, 3 right-bottom
   localparam int NUM_PANELS = 4;

   localparam int NUM_ENTRIES = 64;  // Entries per panel
   localparam int ENTRY_W     = 6;   // Entry index width

   // Entry e sits in group e/8 of eight consecutive entries
   localparam int NUM_GROUPS = 8;
   localparam int GROUP_W    = 3;    // Group index width

   // Panel indices for the read mux wiring
   localparam int PANEL_LT = 0;
   localparam int PANEL_RT = 1;
   localparam int PANEL_LB = 2;
   localparam int PANEL_RB = 3;

endpackage : l2dir_pkg

`default_nettype wire
